// ==== hw/layer_sequencer.sv ====
/*
 * steps through layers, column blocks and row slices of one run
 * i_start is only taken in idle or done, o_layer reads LAYER_NONE outside a run
 */
module layer_sequencer (
    input  logic                        s_clk,
    input  logic                        s_rst,
    input  logic                        i_start,
    input  logic                        i_slice_end,
    input  logic                        i_block_written,
    output mlp_layer_pkg::layer_idx_t   o_layer,
    output mlp_layer_pkg::blk_cnt_t     o_col_blk,
    output logic                        o_prepare,
    output logic                        o_stream_en,
    output logic                        o_fetch_en,
    output logic                        o_calc_done
);
    import mlp_layer_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_INIT, S_STREAM, S_FETCH, S_DONE} state_t;

    state_t   state;
    blk_cnt_t row_cnt;
    logic     last_row;
    logic     last_col;
    logic     last_layer;

    assign last_row   = row_cnt == ROW_BLOCKS[o_layer] - 1'b1;
    assign last_col   = o_col_blk == COL_BLOCKS[o_layer] - 1'b1;
    assign last_layer = o_layer == layer_idx_t'(NUM_LAYERS - 1);

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state     <= S_IDLE;
            o_layer   <= LAYER_NONE;
            o_col_blk <= '0;
            row_cnt   <= '0;
        end else begin
            case (state)
                S_IDLE, S_DONE: begin
                    if (i_start) begin
                        state     <= S_INIT;
                        o_layer   <= '0;
                        o_col_blk <= '0;
                    end
                end
                S_INIT: begin
                    row_cnt <= '0;
                    state   <= S_STREAM;
                end
                S_STREAM: begin
                    if (i_slice_end) begin
                        row_cnt <= row_cnt + 1'b1;
                        if (last_row)
                            state <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (i_block_written) begin
                        if (!last_col) begin
                            o_col_blk <= o_col_blk + 1'b1;
                            state     <= S_INIT;
                        end else if (!last_layer) begin
                            o_layer   <= o_layer + 1'b1;
                            o_col_blk <= '0;
                            state     <= S_INIT;
                        end else begin
                            o_layer <= LAYER_NONE;
                            state   <= S_DONE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign o_prepare   = state == S_INIT;
    assign o_stream_en = state == S_STREAM;
    assign o_fetch_en  = state == S_FETCH;
    assign o_calc_done = state == S_DONE;

    // slices and psum fetch never overlap
    a_stream_fetch_excl: assert property (@(posedge s_clk) disable iff (s_rst)
        o_fetch_en |-> !i_slice_end);

endmodule

// ==== hw/lif_neuron_bank.sv ====
/*
 * integrate-and-fire over the time steps of one sum word
 * membrane starts at zero for every word and resets after a spike
 */
module lif_neuron_bank (
    input  logic                        s_clk,
    input  logic                        s_rst,
    input  logic                        i_valid,
    input  mlp_arch_pkg::sum_word_t     i_sums,
    input  mlp_layer_pkg::layer_idx_t   i_layer,
    output logic                        o_spike_valid,
    output mlp_arch_pkg::spike_t        o_spikes
);
    import mlp_arch_pkg::*;
    import mlp_layer_pkg::*;

    spike_t spikes_nxt;

    always_comb begin
        membrane_t mem;
        mem        = '0;
        spikes_nxt = '0;
        for (int t = 0; t < TIME_STEPS; t++) begin
            mem = mem + membrane_t'($signed(i_sums[t*SUM_LANE_W +: SUM_LANE_W]));
            if (mem >= LIF_THRESH[i_layer]) begin
                spikes_nxt[t] = 1'b1;
                mem           = '0;
            end
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst)
            o_spike_valid <= 1'b0;
        else
            o_spike_valid <= i_valid;
    end

    always_ff @(posedge s_clk) begin
        o_spikes <= spikes_nxt;
    end

endmodule

// ==== hw/mlp_arch_pkg.sv ====
/*
 * datapath widths and vector types of the controller
 * UNIT_NUM must be a power of two, lane t of a psum word sits at bits t*PSUM_LANE_W
 */
package mlp_arch_pkg;

    localparam int ARRAY_NUM   = 3;
    localparam int UNIT_NUM    = 4;
    localparam int FETCH_WORDS = UNIT_NUM * UNIT_NUM;
    localparam int TIME_STEPS  = 4;
    localparam int PSUM_LANE_W = 20;
    localparam int SUM_LANE_W  = PSUM_LANE_W + 2;
    localparam int LANE_BITS   = $clog2(UNIT_NUM);
    localparam int WORD_BITS   = $clog2(FETCH_WORDS);

    typedef logic [63:0]                          slice_t;
    typedef logic [TIME_STEPS*PSUM_LANE_W-1:0]    psum_word_t;
    typedef logic signed [15:0]                   bias_t;
    typedef logic [TIME_STEPS*SUM_LANE_W-1:0]     sum_word_t;
    typedef logic signed [23:0]                   membrane_t;
    typedef logic [TIME_STEPS-1:0]                spike_t;
    typedef logic [UNIT_NUM*TIME_STEPS-1:0]       spike_word_t;
    typedef logic [13:0]                          act_addr_t;
    typedef logic [13:0]                          spk_addr_t;
    typedef logic [11:0]                          bias_addr_t;
    typedef logic [ARRAY_NUM-1:0]                 array_sel_t;
    typedef logic [UNIT_NUM-1:0]                  lane_grant_t;

endpackage

// ==== hw/mlp_controller.sv ====
/*
 * spiking MLP controller driving three systolic arrays
 * activation RAM and bias ROM must answer one cycle after the address
 */
module mlp_controller #(
    parameter int SLICE_BEATS = 4
) (
    input  logic                            s_clk,
    input  logic                            s_rst,
    input  logic                            i_start,
    output logic                            o_prepare,
    output mlp_arch_pkg::act_addr_t         o_act_rd_addr,
    input  mlp_arch_pkg::slice_t            i_act_rd_data,
    output mlp_arch_pkg::array_sel_t        o_slice_valid,
    output mlp_arch_pkg::array_sel_t        o_slice_done,
    output mlp_arch_pkg::slice_t            o_slice_data,
    input  mlp_arch_pkg::array_sel_t        i_slice_ready,
    input  mlp_arch_pkg::array_sel_t        i_finish,
    output mlp_arch_pkg::lane_grant_t       o_psum_grant,
    output logic                            o_psum_valid,
    input  mlp_arch_pkg::psum_word_t        i_psum_data0,
    input  mlp_arch_pkg::psum_word_t        i_psum_data1,
    input  mlp_arch_pkg::psum_word_t        i_psum_data2,
    output mlp_arch_pkg::bias_addr_t        o_bias_addr,
    input  mlp_arch_pkg::bias_t             i_bias_data,
    output logic                            o_spk_wr_en,
    output mlp_arch_pkg::spk_addr_t         o_spk_wr_addr,
    output mlp_arch_pkg::spike_word_t       o_spk_wr_data,
    output logic                            o_calc_done
);
    import mlp_arch_pkg::*;
    import mlp_layer_pkg::*;

    layer_idx_t layer;
    blk_cnt_t   col_blk;
    logic       stream_en;
    logic       fetch_en;
    logic       slice_end;
    logic       block_written;
    logic       word_valid;
    logic       sum_valid;
    logic       spike_valid;
    sum_word_t  sums;
    spike_t     spikes;

    layer_sequencer u_sequencer (
        .s_clk           (s_clk),
        .s_rst           (s_rst),
        .i_start         (i_start),
        .i_slice_end     (slice_end),
        .i_block_written (block_written),
        .o_layer         (layer),
        .o_col_blk       (col_blk),
        .o_prepare       (o_prepare),
        .o_stream_en     (stream_en),
        .o_fetch_en      (fetch_en),
        .o_calc_done     (o_calc_done)
    );

    slice_streamer #(
        .SLICE_BEATS (SLICE_BEATS)
    ) u_streamer (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .i_prepare     (o_prepare),
        .i_stream_en   (stream_en),
        .i_layer       (layer),
        .i_act_rd_data (i_act_rd_data),
        .i_slice_ready (i_slice_ready),
        .o_act_rd_addr (o_act_rd_addr),
        .o_slice_valid (o_slice_valid),
        .o_slice_done  (o_slice_done),
        .o_slice_data  (o_slice_data),
        .o_slice_end   (slice_end)
    );

    psum_fetcher u_fetcher (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_fetch_en   (fetch_en),
        .i_finish     (i_finish),
        .i_layer      (layer),
        .i_col_blk    (col_blk),
        .o_psum_grant (o_psum_grant),
        .o_psum_valid (o_psum_valid),
        .o_bias_addr  (o_bias_addr),
        .o_word_valid (word_valid)
    );

    psum_adder u_adder (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .i_valid     (word_valid),
        .i_psum0     (i_psum_data0),
        .i_psum1     (i_psum_data1),
        .i_psum2     (i_psum_data2),
        .i_bias      (i_bias_data),
        .o_sum_valid (sum_valid),
        .o_sums      (sums)
    );

    lif_neuron_bank u_lif (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .i_valid       (sum_valid),
        .i_sums        (sums),
        .i_layer       (layer),
        .o_spike_valid (spike_valid),
        .o_spikes      (spikes)
    );

    spike_writer u_writer (
        .s_clk           (s_clk),
        .s_rst           (s_rst),
        .i_spike_valid   (spike_valid),
        .i_spikes        (spikes),
        .i_layer         (layer),
        .i_col_blk       (col_blk),
        .o_spk_wr_en     (o_spk_wr_en),
        .o_spk_wr_addr   (o_spk_wr_addr),
        .o_spk_wr_data   (o_spk_wr_data),
        .o_block_written (block_written)
    );

endmodule

// ==== hw/mlp_layer_pkg.sv ====
/*
 * layer schedule for proj, fc1 and fc2, sized for simulation
 * shapes count slices and column blocks, bases are word addresses
 */
package mlp_layer_pkg;

    localparam int NUM_LAYERS = 3;

    typedef logic [1:0] layer_idx_t;
    typedef logic [7:0] blk_cnt_t;

    // layer index seen while no run is in progress
    localparam layer_idx_t LAYER_NONE = layer_idx_t'(NUM_LAYERS);

    localparam blk_cnt_t ROW_BLOCKS [NUM_LAYERS] = '{8'd2, 8'd4, 8'd2};
    localparam blk_cnt_t COL_BLOCKS [NUM_LAYERS] = '{8'd2, 8'd1, 8'd3};

    localparam mlp_arch_pkg::act_addr_t RD_BASE [NUM_LAYERS] =
        '{14'd0, 14'd64, 14'd128};
    localparam mlp_arch_pkg::spk_addr_t WR_BASE [NUM_LAYERS] =
        '{14'd0, 14'd32, 14'd64};
    localparam mlp_arch_pkg::bias_addr_t BIAS_BASE [NUM_LAYERS] =
        '{12'd0, 12'd16, 12'd32};
    localparam mlp_arch_pkg::membrane_t LIF_THRESH [NUM_LAYERS] =
        '{24'sd128, 24'sd256, 24'sd128};

endpackage

// ==== hw/psum_adder.sv ====
/*
 * adds the three array psums and the bias for every time step
 * one register stage, the sum lanes are two bits wider than the psum lanes
 */
module psum_adder (
    input  logic                        s_clk,
    input  logic                        s_rst,
    input  logic                        i_valid,
    input  mlp_arch_pkg::psum_word_t    i_psum0,
    input  mlp_arch_pkg::psum_word_t    i_psum1,
    input  mlp_arch_pkg::psum_word_t    i_psum2,
    input  mlp_arch_pkg::bias_t         i_bias,
    output logic                        o_sum_valid,
    output mlp_arch_pkg::sum_word_t     o_sums
);
    import mlp_arch_pkg::*;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst)
            o_sum_valid <= 1'b0;
        else
            o_sum_valid <= i_valid;
    end

    // all operands signed, so each is sign extended to the sum lane
    always_ff @(posedge s_clk) begin
        for (int t = 0; t < TIME_STEPS; t++) begin
            o_sums[t*SUM_LANE_W +: SUM_LANE_W] <=
                $signed(i_psum0[t*PSUM_LANE_W +: PSUM_LANE_W]) +
                $signed(i_psum1[t*PSUM_LANE_W +: PSUM_LANE_W]) +
                $signed(i_psum2[t*PSUM_LANE_W +: PSUM_LANE_W]) +
                i_bias;
        end
    end

endmodule

// ==== hw/psum_fetcher.sv ====
/*
 * waits for finish from all three arrays, then reads FETCH_WORDS psum words
 * psum and bias data are expected one cycle after the request
 */
module psum_fetcher (
    input  logic                        s_clk,
    input  logic                        s_rst,
    input  logic                        i_fetch_en,
    input  mlp_arch_pkg::array_sel_t    i_finish,
    input  mlp_layer_pkg::layer_idx_t   i_layer,
    input  mlp_layer_pkg::blk_cnt_t     i_col_blk,
    output mlp_arch_pkg::lane_grant_t   o_psum_grant,
    output logic                        o_psum_valid,
    output mlp_arch_pkg::bias_addr_t    o_bias_addr,
    output logic                        o_word_valid
);
    import mlp_arch_pkg::*;
    import mlp_layer_pkg::*;

    array_sel_t             fin_flags;
    logic                   start;
    logic [WORD_BITS-1:0]   word_cnt;
    bias_addr_t             bias_base;

    assign start       = i_fetch_en && !o_psum_valid && &fin_flags;
    assign o_bias_addr = bias_base + bias_addr_t'(word_cnt[LANE_BITS-1:0]);

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            fin_flags    <= '0;
            o_psum_grant <= '0;
            o_psum_valid <= 1'b0;
            o_word_valid <= 1'b0;
            word_cnt     <= '0;
            bias_base    <= '0;
        end else begin
            fin_flags    <= (start ? '0 : fin_flags) | i_finish;
            o_word_valid <= o_psum_valid;
            if (start) begin
                o_psum_valid <= 1'b1;
                o_psum_grant <= lane_grant_t'(1);
                word_cnt     <= '0;
                bias_base    <= bias_addr_t'(BIAS_BASE[i_layer] + i_col_blk * UNIT_NUM);
            end else if (o_psum_valid) begin
                word_cnt <= word_cnt + 1'b1;
                if (word_cnt == WORD_BITS'(FETCH_WORDS - 1)) begin
                    o_psum_valid <= 1'b0;
                    o_psum_grant <= '0;
                end else if (&word_cnt[LANE_BITS-1:0]) begin
                    o_psum_grant <= {o_psum_grant[UNIT_NUM-2:0], o_psum_grant[UNIT_NUM-1]};
                end
            end
        end
    end

    a_grant_onehot: assert property (@(posedge s_clk) disable iff (s_rst)
        o_psum_valid |-> $onehot(o_psum_grant));

endmodule

// ==== hw/slice_streamer.sv ====
/*
 * reads activation slices and sends them to the arrays in turn
 * ready is checked once per slice, the beats then run back to back
 */
module slice_streamer #(
    parameter int SLICE_BEATS = 32
) (
    input  logic                        s_clk,
    input  logic                        s_rst,
    input  logic                        i_prepare,
    input  logic                        i_stream_en,
    input  mlp_layer_pkg::layer_idx_t   i_layer,
    input  mlp_arch_pkg::slice_t        i_act_rd_data,
    input  mlp_arch_pkg::array_sel_t    i_slice_ready,
    output mlp_arch_pkg::act_addr_t     o_act_rd_addr,
    output mlp_arch_pkg::array_sel_t    o_slice_valid,
    output mlp_arch_pkg::array_sel_t    o_slice_done,
    output mlp_arch_pkg::slice_t        o_slice_data,
    output logic                        o_slice_end
);
    import mlp_arch_pkg::*;
    import mlp_layer_pkg::*;

    localparam int CNT_W = $clog2(SLICE_BEATS + 1);

    array_sel_t         grant;
    logic               start;
    logic               busy;
    logic               rd_on;
    logic               rd_last;
    logic [CNT_W-1:0]   beat_cnt;
    logic               data_vld;
    logic               data_last;
    logic               beat_vld;
    logic               beat_last;
    slice_t             beat_data;

    assign start   = i_stream_en && !busy && |(grant & i_slice_ready);
    assign rd_last = rd_on && beat_cnt == CNT_W'(SLICE_BEATS - 1);

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            grant         <= array_sel_t'(1);
            busy          <= 1'b0;
            rd_on         <= 1'b0;
            beat_cnt      <= '0;
            o_act_rd_addr <= '0;
            data_vld      <= 1'b0;
            data_last     <= 1'b0;
            beat_vld      <= 1'b0;
            beat_last     <= 1'b0;
        end else begin
            // address runs on across the slices of one column block
            if (i_prepare)
                o_act_rd_addr <= RD_BASE[i_layer];
            else if (rd_on)
                o_act_rd_addr <= o_act_rd_addr + 1'b1;

            if (start) begin
                rd_on    <= 1'b1;
                beat_cnt <= '0;
            end else if (rd_on) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (rd_last)
                    rd_on <= 1'b0;
            end

            if (start)
                busy <= 1'b1;
            else if (beat_last)
                busy <= 1'b0;

            // one cycle RAM latency plus the output register
            data_vld  <= rd_on;
            data_last <= rd_last;
            beat_vld  <= data_vld;
            beat_last <= data_last;

            if (i_layer == LAYER_NONE)
                grant <= array_sel_t'(1);
            else if (beat_last)
                grant <= {grant[ARRAY_NUM-2:0], grant[ARRAY_NUM-1]};
        end
    end

    always_ff @(posedge s_clk) begin
        beat_data <= i_act_rd_data;
    end

    assign o_slice_valid = beat_vld ? grant : '0;
    assign o_slice_done  = beat_last ? grant : '0;
    assign o_slice_data  = beat_data;
    assign o_slice_end   = beat_last;

    a_one_array: assert property (@(posedge s_clk) disable iff (s_rst)
        $onehot0(o_slice_valid));

endmodule

// ==== hw/spike_writer.sv ====
/*
 * packs UNIT_NUM spike words per lane group into one spike RAM write
 * words of a block must arrive in order, lane group by lane group
 */
module spike_writer (
    input  logic                        s_clk,
    input  logic                        s_rst,
    input  logic                        i_spike_valid,
    input  mlp_arch_pkg::spike_t        i_spikes,
    input  mlp_layer_pkg::layer_idx_t   i_layer,
    input  mlp_layer_pkg::blk_cnt_t     i_col_blk,
    output logic                        o_spk_wr_en,
    output mlp_arch_pkg::spk_addr_t     o_spk_wr_addr,
    output mlp_arch_pkg::spike_word_t   o_spk_wr_data,
    output logic                        o_block_written
);
    import mlp_arch_pkg::*;
    import mlp_layer_pkg::*;

    logic [LANE_BITS-1:0]   word_cnt;
    logic [LANE_BITS-1:0]   grp_cnt;
    logic                   group_full;
    logic                   last_grp;
    spike_word_t            pack;

    assign group_full    = i_spike_valid && word_cnt == LANE_BITS'(UNIT_NUM - 1);
    assign o_spk_wr_data = pack;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            word_cnt        <= '0;
            grp_cnt         <= '0;
            last_grp        <= 1'b0;
            o_spk_wr_en     <= 1'b0;
            o_block_written <= 1'b0;
        end else begin
            o_spk_wr_en     <= group_full;
            o_block_written <= o_spk_wr_en && last_grp;
            if (i_spike_valid)
                word_cnt <= word_cnt + 1'b1;
            if (group_full) begin
                last_grp <= grp_cnt == LANE_BITS'(UNIT_NUM - 1);
                grp_cnt  <= grp_cnt + 1'b1;
            end
        end
    end

    // word w lands at bits w*TIME_STEPS
    always_ff @(posedge s_clk) begin
        if (i_spike_valid)
            pack[word_cnt*TIME_STEPS +: TIME_STEPS] <= i_spikes;
        if (group_full)
            o_spk_wr_addr <= spk_addr_t'(WR_BASE[i_layer] + i_col_blk * UNIT_NUM + grp_cnt);
    end

endmodule

// ==== mlp_controller.f ====
+incdir+tests
hw/mlp_arch_pkg.sv
hw/mlp_layer_pkg.sv
hw/layer_sequencer.sv
hw/slice_streamer.sv
hw/psum_fetcher.sv
hw/psum_adder.sv
hw/lif_neuron_bank.sv
hw/spike_writer.sv
hw/mlp_controller.sv
tests/tb_mlp_controller.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mlp_controller.f \
    --top-module tb_mlp_controller -Mdir build
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./build/Vtb_mlp_controller > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test failures found" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

// ==== tests/tb_mlp_model.svh ====
/*
 * memory, array responder and LIF models for the controller testbench
 * included inside tb_mlp_controller, relies on its seed and imports
 */
slice_t     act_mem [0:16383];
bias_t      bias_mem [0:4095];
spk_addr_t  exp_addr [$];
spike_word_t exp_data [$];
int         fin_timer [ARRAY_NUM];
array_sel_t fin_seen;
act_addr_t  act_addr_q;
bias_addr_t bias_addr_q;
psum_word_t psum_pend [ARRAY_NUM];
// psum words on their way back, one cycle after the request
psum_word_t psum_resp [ARRAY_NUM];

task automatic fill_memories();
    for (int a = 0; a < 16384; a++)
        act_mem[a] = {$random(seed), $random(seed)};
    for (int a = 0; a < 4096; a++)
        bias_mem[a] = bias_t'($random(seed));
endtask

function automatic psum_word_t random_psum();
    logic [95:0] r;
    r = {$random(seed), $random(seed), $random(seed)};
    return r[TIME_STEPS*PSUM_LANE_W-1:0];
endfunction

// reference LIF over one word of three psums plus bias
function automatic spike_t lif_expect(psum_word_t p0, psum_word_t p1, psum_word_t p2,
                                      bias_t b, int thresh);
    int     lane0;
    int     lane1;
    int     lane2;
    int     mem;
    spike_t s;
    mem = 0;
    s   = '0;
    for (int t = 0; t < TIME_STEPS; t++) begin
        lane0 = $signed(p0[t*PSUM_LANE_W +: PSUM_LANE_W]);
        lane1 = $signed(p1[t*PSUM_LANE_W +: PSUM_LANE_W]);
        lane2 = $signed(p2[t*PSUM_LANE_W +: PSUM_LANE_W]);
        mem   = mem + lane0 + lane1 + lane2 + int'(b);
        if (mem >= thresh) begin
            s[t] = 1'b1;
            mem  = 0;
        end
    end
    return s;
endfunction

// ==== tests/tb_mlp_controller.sv ====
/*
 * random test of the MLP controller over two complete runs
 * arrays, RAM and ROM are modelled here, stops at the first mismatch
 */
module tb_mlp_controller;
    import mlp_arch_pkg::*;
    import mlp_layer_pkg::*;

    localparam int SLICE_BEATS   = 4;
    localparam int TOTAL_SLICES  = 14;
    localparam int TOTAL_BLOCKS  = 6;
    localparam int TIMEOUT_CYCLES = (TOTAL_SLICES * (SLICE_BEATS + 8) + TOTAL_BLOCKS * 40) * 2;

    logic s_clk, s_rst, i_start;
    logic o_prepare, o_psum_valid, o_spk_wr_en, o_calc_done;
    act_addr_t o_act_rd_addr;
    slice_t i_act_rd_data, o_slice_data;
    array_sel_t o_slice_valid, o_slice_done, i_slice_ready, i_finish;
    lane_grant_t o_psum_grant;
    psum_word_t i_psum_data0, i_psum_data1, i_psum_data2;
    bias_addr_t o_bias_addr;
    bias_t i_bias_data;
    spk_addr_t o_spk_wr_addr;
    spike_word_t o_spk_wr_data;

    int seed = 91182;
    int errors = 0;
    int cycle_cnt = 0;
    int slice_n, beat_idx, blk_off, blk_slices, blk_idx, word_idx;
    int cur_layer, cur_col, writes_done, prepares;
    logic run_finished, calc_prev;
    array_sel_t ready_hist [3];
    spike_word_t grp_pack;

    `include "tb_mlp_model.svh"

    mlp_controller #(.SLICE_BEATS(SLICE_BEATS)) u_mlp_controller (
        .s_clk(s_clk), .s_rst(s_rst), .i_start(i_start), .o_prepare(o_prepare),
        .o_act_rd_addr(o_act_rd_addr), .i_act_rd_data(i_act_rd_data),
        .o_slice_valid(o_slice_valid), .o_slice_done(o_slice_done),
        .o_slice_data(o_slice_data), .i_slice_ready(i_slice_ready), .i_finish(i_finish),
        .o_psum_grant(o_psum_grant), .o_psum_valid(o_psum_valid),
        .i_psum_data0(i_psum_data0), .i_psum_data1(i_psum_data1),
        .i_psum_data2(i_psum_data2), .o_bias_addr(o_bias_addr), .i_bias_data(i_bias_data),
        .o_spk_wr_en(o_spk_wr_en), .o_spk_wr_addr(o_spk_wr_addr),
        .o_spk_wr_data(o_spk_wr_data), .o_calc_done(o_calc_done)
    );

    task automatic check_value(string name, logic [127:0] got, logic [127:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic fail_plain(string msg);
        errors++;
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    // walks the layer table to find block b
    task automatic locate_block(int b, output int layer, output int col);
        int n;
        n = b;
        layer = 0;
        while (n >= COL_BLOCKS[layer]) begin
            n = n - COL_BLOCKS[layer];
            layer++;
        end
        col = n;
    endtask

    task automatic monitor_cycle();
        array_sel_t sel;
        bias_t      b;
        spike_t     s;
        bias_addr_t bias_exp;
        ready_hist[2] = ready_hist[1];
        ready_hist[1] = ready_hist[0];
        ready_hist[0] = i_slice_ready;
        if (o_prepare) begin
            prepares++;
            locate_block(blk_idx, cur_layer, cur_col);
            blk_idx++;
            blk_off = 0;
            blk_slices = 0;
        end
        sel = array_sel_t'(1 << (slice_n % ARRAY_NUM));
        if (o_slice_valid != 0 || beat_idx > 0) begin
            check_value("o_slice_valid", o_slice_valid, sel);
            if (beat_idx == 0 && !ready_hist[2][slice_n % ARRAY_NUM])
                fail_plain("a slice started on an array that was not ready");
            check_value("o_slice_data", o_slice_data, act_mem[RD_BASE[cur_layer] + blk_off]);
            check_value("o_slice_done", o_slice_done, beat_idx == SLICE_BEATS - 1 ? sel : 0);
            blk_off++;
            beat_idx++;
            if (beat_idx == SLICE_BEATS) begin
                beat_idx = 0;
                slice_n++;
                blk_slices++;
                if (blk_slices == ROW_BLOCKS[cur_layer])
                    for (int a = 0; a < ARRAY_NUM; a++)
                        fin_timer[a] = 1 + ($random(seed) & 7);
            end
        end else begin
            check_value("o_slice_done", o_slice_done, 0);
        end
        if (word_idx > 0 && !o_psum_valid)
            fail_plain("psum fetch ended before all words were requested");
        if (o_psum_valid) begin
            if (word_idx == 0) begin
                if (fin_seen != 3'b111)
                    fail_plain("psum fetch started before all arrays finished");
                check_value("slices_in_block", blk_slices, ROW_BLOCKS[cur_layer]);
                fin_seen = '0;
            end
            check_value("o_psum_grant", o_psum_grant, 1 << (word_idx / UNIT_NUM));
            bias_exp = bias_addr_t'(BIAS_BASE[cur_layer] + cur_col * UNIT_NUM
                                    + word_idx % UNIT_NUM);
            check_value("o_bias_addr", o_bias_addr, bias_exp);
            for (int a = 0; a < ARRAY_NUM; a++)
                psum_pend[a] = random_psum();
            b = bias_mem[bias_exp];
            s = lif_expect(psum_pend[0], psum_pend[1], psum_pend[2], b, LIF_THRESH[cur_layer]);
            grp_pack[(word_idx % UNIT_NUM) * TIME_STEPS +: TIME_STEPS] = s;
            if (word_idx % UNIT_NUM == UNIT_NUM - 1) begin
                exp_addr.push_back(WR_BASE[cur_layer] + cur_col * UNIT_NUM + word_idx / UNIT_NUM);
                exp_data.push_back(grp_pack);
            end
            word_idx = (word_idx + 1) % FETCH_WORDS;
        end
        if (o_spk_wr_en) begin
            if (exp_addr.size() == 0)
                fail_plain("spike RAM write with no expected result");
            check_value("o_spk_wr_addr", o_spk_wr_addr, exp_addr.pop_front());
            check_value("o_spk_wr_data", o_spk_wr_data, exp_data.pop_front());
            writes_done++;
        end
        if (o_calc_done && !calc_prev) begin
            check_value("spike_writes", writes_done, TOTAL_BLOCKS * UNIT_NUM);
            check_value("prepare_pulses", prepares, TOTAL_BLOCKS);
            run_finished = 1'b1;
        end
        calc_prev = o_calc_done;
    endtask

    task automatic drive_cycle();
        logic [31:0] r;
        i_act_rd_data = act_mem[act_addr_q];
        act_addr_q    = o_act_rd_addr;
        i_bias_data   = bias_mem[bias_addr_q];
        bias_addr_q   = o_bias_addr;
        i_psum_data0  = psum_resp[0];
        i_psum_data1  = psum_resp[1];
        i_psum_data2  = psum_resp[2];
        for (int a = 0; a < ARRAY_NUM; a++)
            psum_resp[a] = psum_pend[a];
        r = $random(seed);
        for (int a = 0; a < ARRAY_NUM; a++) begin
            i_slice_ready[a] = r[2*a +: 2] != 2'b00;
            i_finish[a] = 1'b0;
            if (fin_timer[a] > 0) begin
                fin_timer[a]--;
                i_finish[a] = fin_timer[a] == 0;
            end
        end
        fin_seen = fin_seen | i_finish;
    endtask

    initial begin
        s_clk = 1'b0;
        forever #2 s_clk = ~s_clk;
    end

    initial begin
        forever begin
            @(posedge s_clk);
            cycle_cnt++;
            if (cycle_cnt > TIMEOUT_CYCLES + 16)
                fail_plain("timeout waiting for the runs to complete");
        end
    end

    initial begin
        forever begin
            @(posedge s_clk);
            #1;
            if (!s_rst) begin
                monitor_cycle();
                drive_cycle();
            end
        end
    end

    initial begin
        s_rst = 1'b1;
        i_start = 1'b0;
        i_act_rd_data = '0;
        i_slice_ready = '0;
        i_finish = '0;
        i_psum_data0 = '0;
        i_psum_data1 = '0;
        i_psum_data2 = '0;
        i_bias_data = '0;
        act_addr_q = '0;
        bias_addr_q = '0;
        fin_seen = '0;
        calc_prev = 1'b0;
        grp_pack = '0;
        for (int a = 0; a < ARRAY_NUM; a++) begin
            fin_timer[a] = 0;
            psum_pend[a] = '0;
            psum_resp[a] = '0;
            ready_hist[a] = '0;
        end
        fill_memories();
        repeat (16) @(posedge s_clk);
        #1;
        check_value("reset_outputs",
                    {o_slice_valid, o_slice_done, o_psum_valid, o_spk_wr_en, o_prepare,
                     o_calc_done, o_psum_grant}, 0);
        s_rst = 1'b0;
        for (int run = 0; run < 2; run++) begin
            @(posedge s_clk);
            #1;
            slice_n = 0;
            beat_idx = 0;
            blk_idx = 0;
            word_idx = 0;
            writes_done = 0;
            prepares = 0;
            run_finished = 1'b0;
            i_start = 1'b1;
            @(posedge s_clk);
            #1;
            i_start = 1'b0;
            @(posedge s_clk);
            #1;
            check_value("o_calc_done", o_calc_done, 0);
            while (!run_finished)
                @(posedge s_clk);
        end
        repeat (4) @(posedge s_clk);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule
